// File: float_to_fixed.f
+incdir+source
source/fxp_pkg.sv
source/fxp_classify.sv
source/fxp_align.sv
source/fxp_round.sv
source/fxp_saturate.sv
source/float_to_fixed.sv
sim/float_to_fixed_props.sv
sim/tb_float_to_fixed.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_float_to_fixed
FILELIST  := float_to_fixed.f
FLAGS     := --binary --timing --assert -Wno-fatal
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard source/*.sv source/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// File: sim/tb_float_to_fixed.sv
`timescale 1ns/100ps
`include "fxp_macros.svh"

module tb_float_to_fixed;

    localparam int INT_W        = `FXP_INT_WID;
    localparam int FRA_W        = `FXP_FRA_WID;
    localparam int RES_W        = INT_W + FRA_W;
    localparam int LATENCY      = 5;
    localparam int NUM_DIRECTED = 22;
    localparam int NUM_RANDOM   = 1970;
    // one stall in eight, twice the vector count leaves room for reset and drain
    localparam int MAX_CYCLES   = 2 * (NUM_DIRECTED + NUM_RANDOM) + 16;

    localparam logic [31:0] MIN_WORD = {1'b1, 8'(`FLT_EXP_BIAS + INT_W - 1), 23'b0};
    localparam longint VAL_MAX = (64'sd1 <<< (RES_W - 1)) - 1;
    localparam longint VAL_MIN = -(64'sd1 <<< (RES_W - 1));

    logic clk = 1'b0;
    logic rstn;
    logic en;
    fxp_pkg::float_word_t float_val;
    logic overflow, underflow, nan, infinity, denorm, zero;
    fxp_pkg::fix_int_t fixed_integer;
    fxp_pkg::fix_fra_t fixed_fraction;

    integer seed = 32'hef2f;
    int num_applied = 0;
    int num_checked = 0;
    int num_errors = 0;
    int cycle_count = 0;
    logic edge_seen = 1'b0;
    logic [31:0] in_q[$];

    logic [31:0] directed [NUM_DIRECTED] = '{
        32'h3f800000, 32'hbfa00000, 32'h3f000000, 32'hbf000000, 32'h40300000,
        32'hc0400000, 32'h42c88000, 32'hc2c88000, 32'h37000000, 32'hb7000000,
        32'h37c00000, 32'h36ffffff, 32'h00000000, 32'h80000000, 32'h00000001,
        32'h7fc00000, 32'h7f800000, 32'hff800000, 32'h47000000, 32'hc7000000,
        32'h46ffffff, 32'hc6ffffff
    };

    float_to_fixed float_to_fixed_inst (.*);

    always #2 clk = ~clk;

    // {overflow, underflow, nan, inf, denorm, zero, integer, fraction}
    function automatic logic [RES_W+5:0] ref_convert(input logic [31:0] w);
        int          e;
        int          shift;
        logic [22:0] m;
        logic        is_zero, is_den, is_nan, is_inf, is_min, ovf, unf;
        longint      mag, val;
        e       = int'(w[30:23]);
        m       = w[22:0];
        is_zero = (e == 0) && (m == 0);
        is_den  = (e == 0) && (m != 0);
        is_nan  = (e == 255) && (m != 0);
        is_inf  = (e == 255) && (m == 0);
        is_min  = (w == MIN_WORD);
        ovf     = (e - `FLT_EXP_BIAS > INT_W - 2) && !is_min;
        unf     = (e - `FLT_EXP_BIAS < -(FRA_W + 1));
        if (is_zero || is_den || is_nan || unf) begin
            val = 0;
        end else if (is_inf || ovf || is_min) begin
            val = w[31] ? VAL_MIN : VAL_MAX;
        end else begin
            // magnitude in half LSBs, lower bits dropped
            shift = e - `FLT_EXP_BIAS - `FLT_MANT_WID + FRA_W + 1;
            mag   = longint'({1'b1, m});
            mag   = (shift >= 0) ? (mag <<< shift) : (mag >>> (-shift));
            val   = (mag + 1) >>> 1;  // half up on the magnitude
            val   = w[31] ? -val : val;
            if (val > VAL_MAX)
                val = VAL_MAX;
        end
        if (is_inf) begin
            ovf = 1'b1;
        end else if (is_zero || is_den || is_nan) begin
            ovf = 1'b0;
            unf = 1'b0;
        end
        return {ovf, unf, is_nan, is_inf, is_den, is_zero, val[RES_W-1:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            num_errors++;
            $display("FAIL time %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic compare_outputs(input logic [31:0] word);
        logic [RES_W+5:0] exp_res;
        exp_res = ref_convert(word);
        check_value("overflow", 32'(exp_res[RES_W+5]), 32'(overflow));
        check_value("underflow", 32'(exp_res[RES_W+4]), 32'(underflow));
        check_value("nan", 32'(exp_res[RES_W+3]), 32'(nan));
        check_value("infinity", 32'(exp_res[RES_W+2]), 32'(infinity));
        check_value("denorm", 32'(exp_res[RES_W+1]), 32'(denorm));
        check_value("zero", 32'(exp_res[RES_W]), 32'(zero));
        check_value("fixed_integer", 32'(exp_res[RES_W-1:FRA_W]), 32'($unsigned(fixed_integer)));
        check_value("fixed_fraction", 32'(exp_res[FRA_W-1:0]), 32'(fixed_fraction));
        num_checked++;
    endtask

    task automatic apply_word(input logic [31:0] word, input logic stall);
        if (stall) begin
            @(negedge clk);
            en        = 1'b0;
            float_val = ~word;  // must not enter the pipeline
        end
        @(negedge clk);
        en        = 1'b1;
        float_val = word;
        num_applied++;
    endtask

    always @(posedge clk) begin
        if (rstn && en) begin
            in_q.push_back(float_val);
            edge_seen = 1'b1;
        end
    end

    // outputs settle after the edge, compare half a cycle later
    always @(negedge clk) begin
        if (edge_seen) begin
            edge_seen = 1'b0;
            if (in_q.size() == LATENCY)
                compare_outputs(in_q.pop_front());
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout, results still missing after %0d cycles", MAX_CYCLES);
        end
    end

    initial begin
        logic [31:0] word;
        logic [31:0] pick;
        rstn      = 1'b0;
        en        = 1'b0;
        float_val = '0;
        repeat (16) @(negedge clk);
        rstn = 1'b1;

        foreach (directed[i])
            apply_word(directed[i], (i % 4) == 3);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            word = $random(seed);
            pick = $random(seed);
            case (pick[1:0])
                2'd0, 2'd1: word[30:23] = 8'(105 + pick[7:2] % 42);  // near the window
                2'd2: if (pick[2]) word[30:23] = pick[3] ? 8'hff : 8'h00;
                default: ;
            endcase
            apply_word(word, pick[10:8] == 3'd0);
        end

        @(negedge clk);
        float_val = '0;  // flush with zeros
        while (num_checked < num_applied)
            @(negedge clk);

        if (num_errors == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "%0d wrong output values", num_errors);
        end
    end

endmodule

// File: sim/float_to_fixed_props.sv
`timescale 1ns/100ps
`include "fxp_macros.svh"

module float_to_fixed_props (
    input logic              clk,
    input logic              rstn,
    input logic              en,
    input logic              overflow,
    input logic              underflow,
    input logic              nan,
    input logic              infinity,
    input logic              denorm,
    input logic              zero,
    input fxp_pkg::fix_int_t fixed_integer,
    input fxp_pkg::fix_fra_t fixed_fraction
);

    logic [`FXP_INT_WID+`FXP_FRA_WID+5:0] out_bits;

    assign out_bits = {overflow, underflow, nan, infinity, denorm, zero,
                       fixed_integer, fixed_fraction};

    hold_when_idle: assert property (@(posedge clk) disable iff (!rstn)
        !en |=> $stable(out_bits))
        else $error("outputs changed while en was low");

    one_class: assert property (@(posedge clk) $onehot0({nan, infinity, denorm, zero}))
        else $error("more than one class flag is high");

    underflow_gives_zero: assert property (@(posedge clk)
        underflow |-> (fixed_integer == '0 && fixed_fraction == '0))
        else $error("underflow with a nonzero result");

    zero_after_reset: assert property (@(posedge clk) $rose(rstn) |-> (out_bits == '0))
        else $error("outputs not zero after reset");

endmodule

bind float_to_fixed float_to_fixed_props props_inst (
    .clk(clk), .rstn(rstn), .en(en),
    .overflow(overflow), .underflow(underflow),
    .nan(nan), .infinity(infinity), .denorm(denorm), .zero(zero),
    .fixed_integer(fixed_integer), .fixed_fraction(fixed_fraction)
);

// File: source/float_to_fixed.sv
`timescale 1ns/100ps
`include "fxp_macros.svh"

module float_to_fixed (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 en,
    input  fxp_pkg::float_word_t float_val,
    output logic                 overflow,
    output logic                 underflow,
    output logic                 nan,
    output logic                 infinity,
    output logic                 denorm,
    output logic                 zero,
    output fxp_pkg::fix_int_t    fixed_integer,
    output fxp_pkg::fix_fra_t    fixed_fraction
);

    fxp_pkg::mant1_t      mant_step1;
    fxp_pkg::shift_rest_t shift_rest;
    logic s1_sign, s1_nan, s1_inf, s1_denorm, s1_zero;
    logic s1_overflow, s1_underflow, s1_min_exact;

    fxp_pkg::aligned_t aligned;
    logic s3_sign, s3_nan, s3_inf, s3_denorm, s3_zero;
    logic s3_overflow, s3_underflow, s3_result_clr, s3_result_set;

    fxp_pkg::fix_int_t     mag_int;
    fxp_pkg::fix_fra_t     mag_fra;
    logic [`FXP_FRA_WID:0] neg_fra;
    logic s4_sign, s4_nan, s4_inf, s4_denorm, s4_zero;
    logic s4_overflow, s4_underflow, s4_result_clr, s4_result_set;

    fxp_classify classify_inst (
        .clk        (clk),
        .rstn       (rstn),
        .en         (en),
        .float_val  (float_val),
        .mant_step1 (mant_step1),
        .shift_rest (shift_rest),
        .sign       (s1_sign),
        .nan        (s1_nan),
        .inf        (s1_inf),
        .denorm     (s1_denorm),
        .zero       (s1_zero),
        .overflow   (s1_overflow),
        .underflow  (s1_underflow),
        .min_exact  (s1_min_exact)
    );

    fxp_align align_inst (
        .clk(clk), .rstn(rstn), .en(en),
        .mant_step1(mant_step1), .shift_rest(shift_rest),
        .s1_sign(s1_sign), .s1_nan(s1_nan), .s1_inf(s1_inf),
        .s1_denorm(s1_denorm), .s1_zero(s1_zero), .s1_overflow(s1_overflow),
        .s1_underflow(s1_underflow), .s1_min_exact(s1_min_exact),
        .aligned(aligned),
        .s3_sign(s3_sign), .s3_nan(s3_nan), .s3_inf(s3_inf),
        .s3_denorm(s3_denorm), .s3_zero(s3_zero), .s3_overflow(s3_overflow),
        .s3_underflow(s3_underflow),
        .s3_result_clr(s3_result_clr), .s3_result_set(s3_result_set)
    );

    fxp_round round_inst (
        .clk(clk), .rstn(rstn), .en(en),
        .aligned(aligned),
        .s3_sign(s3_sign), .s3_nan(s3_nan), .s3_inf(s3_inf),
        .s3_denorm(s3_denorm), .s3_zero(s3_zero), .s3_overflow(s3_overflow),
        .s3_underflow(s3_underflow),
        .s3_result_clr(s3_result_clr), .s3_result_set(s3_result_set),
        .mag_int(mag_int), .mag_fra(mag_fra), .neg_fra(neg_fra),
        .s4_sign(s4_sign), .s4_nan(s4_nan), .s4_inf(s4_inf),
        .s4_denorm(s4_denorm), .s4_zero(s4_zero), .s4_overflow(s4_overflow),
        .s4_underflow(s4_underflow),
        .s4_result_clr(s4_result_clr), .s4_result_set(s4_result_set)
    );

    fxp_saturate saturate_inst (
        .clk(clk), .rstn(rstn), .en(en),
        .mag_int(mag_int), .mag_fra(mag_fra), .neg_fra(neg_fra),
        .s4_sign(s4_sign), .s4_nan(s4_nan), .s4_inf(s4_inf),
        .s4_denorm(s4_denorm), .s4_zero(s4_zero), .s4_overflow(s4_overflow),
        .s4_underflow(s4_underflow),
        .s4_result_clr(s4_result_clr), .s4_result_set(s4_result_set),
        .overflow(overflow), .underflow(underflow),
        .nan(nan), .infinity(infinity), .denorm(denorm), .zero(zero),
        .fixed_integer(fixed_integer), .fixed_fraction(fixed_fraction)
    );

endmodule

// File: source/fxp_saturate.sv
`timescale 1ns/100ps
`include "fxp_macros.svh"

module fxp_saturate (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  en,
    input  fxp_pkg::fix_int_t     mag_int,
    input  fxp_pkg::fix_fra_t     mag_fra,
    input  logic [`FXP_FRA_WID:0] neg_fra,
    input  logic                  s4_sign,
    input  logic                  s4_nan,
    input  logic                  s4_inf,
    input  logic                  s4_denorm,
    input  logic                  s4_zero,
    input  logic                  s4_overflow,
    input  logic                  s4_underflow,
    input  logic                  s4_result_clr,
    input  logic                  s4_result_set,
    output logic                  overflow,
    output logic                  underflow,
    output logic                  nan,
    output logic                  infinity,
    output logic                  denorm,
    output logic                  zero,
    output fxp_pkg::fix_int_t     fixed_integer,
    output fxp_pkg::fix_fra_t     fixed_fraction
);

    localparam fxp_pkg::fix_int_t INT_MAX = {1'b0, {(`FXP_INT_WID-1){1'b1}}};
    localparam fxp_pkg::fix_int_t INT_MIN = {1'b1, {(`FXP_INT_WID-1){1'b0}}};

    fxp_pkg::fix_int_t int_signed;
    fxp_pkg::fix_fra_t fra_signed;

    // negative value becomes floor integer plus positive fraction
    always_comb begin
        if (s4_sign) begin
            int_signed = ~mag_int + {{(`FXP_INT_WID-1){1'b0}}, neg_fra[`FXP_FRA_WID]};
            fra_signed = neg_fra[`FXP_FRA_WID-1:0];
        end else begin
            int_signed = mag_int;
            fra_signed = mag_fra;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            overflow       <= 1'b0;
            underflow      <= 1'b0;
            nan            <= 1'b0;
            infinity       <= 1'b0;
            denorm         <= 1'b0;
            zero           <= 1'b0;
            fixed_integer  <= '0;
            fixed_fraction <= '0;
        end else if (en) begin
            nan      <= s4_nan;
            infinity <= s4_inf;
            denorm   <= s4_denorm;
            zero     <= s4_zero;

            if (s4_inf) begin
                overflow  <= 1'b1;
                underflow <= 1'b0;
            end else if (s4_zero | s4_nan | s4_denorm) begin
                overflow  <= 1'b0;
                underflow <= 1'b0;
            end else begin
                overflow  <= s4_overflow;
                underflow <= s4_underflow;
            end

            if (s4_result_clr) begin
                fixed_integer  <= '0;
                fixed_fraction <= '0;
            end else if (s4_result_set) begin
                fixed_integer  <= s4_sign ? INT_MIN : INT_MAX;
                fixed_fraction <= s4_sign ? '0 : '1;
            end else if (!s4_sign && int_signed[`FXP_INT_WID-1]) begin  // rounded into sign bit
                fixed_integer  <= INT_MAX;
                fixed_fraction <= '1;
            end else begin
                fixed_integer  <= int_signed;
                fixed_fraction <= fra_signed;
            end
        end
    end

endmodule

// File: source/fxp_round.sv
`timescale 1ns/100ps
`include "fxp_macros.svh"

module fxp_round (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  en,
    input  fxp_pkg::aligned_t     aligned,
    input  logic                  s3_sign,
    input  logic                  s3_nan,
    input  logic                  s3_inf,
    input  logic                  s3_denorm,
    input  logic                  s3_zero,
    input  logic                  s3_overflow,
    input  logic                  s3_underflow,
    input  logic                  s3_result_clr,
    input  logic                  s3_result_set,
    output fxp_pkg::fix_int_t     mag_int,
    output fxp_pkg::fix_fra_t     mag_fra,
    output logic [`FXP_FRA_WID:0] neg_fra,
    output logic                  s4_sign,
    output logic                  s4_nan,
    output logic                  s4_inf,
    output logic                  s4_denorm,
    output logic                  s4_zero,
    output logic                  s4_overflow,
    output logic                  s4_underflow,
    output logic                  s4_result_clr,
    output logic                  s4_result_set
);

    logic [`FXP_FRA_WID:0]   fra_rnd;  // msb is the carry into the integer
    logic [`FXP_INT_WID-1:0] int_rnd;

    assign fra_rnd = {1'b0, aligned[`FXP_FRA_WID:1]} + {{`FXP_FRA_WID{1'b0}}, aligned[0]};
    assign int_rnd = aligned[`FXP_INT_WID+`FXP_FRA_WID:`FXP_FRA_WID+1]
                   + {{(`FXP_INT_WID-1){1'b0}}, fra_rnd[`FXP_FRA_WID]};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mag_int       <= '0;
            mag_fra       <= '0;
            neg_fra       <= '0;
            s4_sign       <= 1'b0;
            s4_nan        <= 1'b0;
            s4_inf        <= 1'b0;
            s4_denorm     <= 1'b0;
            s4_zero       <= 1'b0;
            s4_overflow   <= 1'b0;
            s4_underflow  <= 1'b0;
            s4_result_clr <= 1'b0;
            s4_result_set <= 1'b0;
        end else if (en) begin
            mag_int <= int_rnd;
            mag_fra <= fra_rnd[`FXP_FRA_WID-1:0];
            // 2^FRA - frac, carry set only when frac is zero
            neg_fra <= {1'b0, ~fra_rnd[`FXP_FRA_WID-1:0]} + {{`FXP_FRA_WID{1'b0}}, 1'b1};

            s4_sign       <= s3_sign;
            s4_nan        <= s3_nan;
            s4_inf        <= s3_inf;
            s4_denorm     <= s3_denorm;
            s4_zero       <= s3_zero;
            s4_overflow   <= s3_overflow;
            s4_underflow  <= s3_underflow;
            s4_result_clr <= s3_result_clr;
            s4_result_set <= s3_result_set;
        end
    end

endmodule

// File: source/fxp_align.sv
`timescale 1ns/100ps
`include "fxp_macros.svh"

module fxp_align (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 en,
    input  fxp_pkg::mant1_t      mant_step1,
    input  fxp_pkg::shift_rest_t shift_rest,
    input  logic                 s1_sign,
    input  logic                 s1_nan,
    input  logic                 s1_inf,
    input  logic                 s1_denorm,
    input  logic                 s1_zero,
    input  logic                 s1_overflow,
    input  logic                 s1_underflow,
    input  logic                 s1_min_exact,
    output fxp_pkg::aligned_t    aligned,
    output logic                 s3_sign,
    output logic                 s3_nan,
    output logic                 s3_inf,
    output logic                 s3_denorm,
    output logic                 s3_zero,
    output logic                 s3_overflow,
    output logic                 s3_underflow,
    output logic                 s3_result_clr,
    output logic                 s3_result_set
);

    localparam int S1 = `FXP_STEP1_WID;
    localparam int S2 = `FXP_STEP2_WID;
    localparam int S3 = `FXP_STEP3_WID;
    localparam int W2 = `FLT_MANT_WID + (1 << (S1 + S2));
    localparam int W3 = `FLT_MANT_WID + (1 << `FXP_SHIFT_WID);

    logic [W2-1:0] mant2;
    logic [S3-1:0] shift_last;
    logic [W3-1:0] mant3;
    logic sign2, nan2, inf2, denorm2, zero2;
    logic overflow2, underflow2, result_clr2, result_set2;

    assign mant3 = W3'(mant2) << {shift_last, {(S1 + S2){1'b0}}};

    // stage 2
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mant2       <= '0;
            shift_last  <= '0;
            sign2       <= 1'b0;
            nan2        <= 1'b0;
            inf2        <= 1'b0;
            denorm2     <= 1'b0;
            zero2       <= 1'b0;
            overflow2   <= 1'b0;
            underflow2  <= 1'b0;
            result_clr2 <= 1'b0;
            result_set2 <= 1'b0;
        end else if (en) begin
            mant2       <= W2'(mant_step1) << {shift_rest[S2-1:0], {S1{1'b0}}};
            shift_last  <= shift_rest[S2 +: S3];
            sign2       <= s1_sign;
            nan2        <= s1_nan;
            inf2        <= s1_inf;
            denorm2     <= s1_denorm;
            zero2       <= s1_zero;
            overflow2   <= s1_overflow;
            underflow2  <= s1_underflow;
            result_clr2 <= s1_zero | s1_nan | s1_denorm | s1_underflow;  // result forced to 0
            result_set2 <= s1_inf | s1_overflow | s1_min_exact;          // max or min
        end
    end

    // stage 3
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            aligned       <= '0;
            s3_sign       <= 1'b0;
            s3_nan        <= 1'b0;
            s3_inf        <= 1'b0;
            s3_denorm     <= 1'b0;
            s3_zero       <= 1'b0;
            s3_overflow   <= 1'b0;
            s3_underflow  <= 1'b0;
            s3_result_clr <= 1'b0;
            s3_result_set <= 1'b0;
        end else if (en) begin
            aligned       <= {1'b0, mant3[`FLT_MANT_WID +: `FXP_INT_WID + `FXP_FRA_WID]};
            s3_sign       <= sign2;
            s3_nan        <= nan2;
            s3_inf        <= inf2;
            s3_denorm     <= denorm2;
            s3_zero       <= zero2;
            s3_overflow   <= overflow2;
            s3_underflow  <= underflow2;
            s3_result_clr <= result_clr2;
            s3_result_set <= result_set2;
        end
    end

endmodule

// File: source/fxp_classify.sv
`timescale 1ns/100ps
`include "fxp_macros.svh"

module fxp_classify (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 en,
    input  fxp_pkg::float_word_t float_val,
    output fxp_pkg::mant1_t      mant_step1,
    output fxp_pkg::shift_rest_t shift_rest,
    output logic                 sign,
    output logic                 nan,
    output logic                 inf,
    output logic                 denorm,
    output logic                 zero,
    output logic                 overflow,
    output logic                 underflow,
    output logic                 min_exact
);

    // biased exponent window that fits the fixed format
    localparam int EXP_HI = `FLT_EXP_BIAS + `FXP_INT_WID - 2;
    localparam int EXP_LO = `FLT_EXP_BIAS - `FXP_FRA_WID - 1;

    // -2^(INT-1) is representable, keep it out of overflow
    localparam fxp_pkg::float_word_t MIN_WORD =
        {1'b1, fxp_pkg::exp_t'(EXP_HI + 1), {`FLT_MANT_WID{1'b0}}};

    fxp_pkg::exp_t   exp_f;
    fxp_pkg::mant_t  mant_f;
    fxp_pkg::exp_t   shift_full;
    fxp_pkg::shift_t shift_amt;
    logic            exp_zero;
    logic            exp_ones;
    logic            mant_zero;

    assign exp_f     = float_val[`FLT_MANT_WID +: `FLT_EXP_WID];
    assign mant_f    = float_val[`FLT_MANT_WID-1:0];
    assign exp_zero  = (exp_f == '0);
    assign exp_ones  = (exp_f == '1);
    assign mant_zero = (mant_f == '0);

    assign shift_full = exp_f - fxp_pkg::exp_t'(EXP_LO);  // garbage outside window, flagged
    assign shift_amt  = shift_full[`FXP_SHIFT_WID-1:0];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mant_step1 <= '0;
            shift_rest <= '0;
            sign       <= 1'b0;
            nan        <= 1'b0;
            inf        <= 1'b0;
            denorm     <= 1'b0;
            zero       <= 1'b0;
            overflow   <= 1'b0;
            underflow  <= 1'b0;
            min_exact  <= 1'b0;
        end else if (en) begin
            mant_step1 <= fxp_pkg::mant1_t'({1'b1, mant_f}) << shift_amt[`FXP_STEP1_WID-1:0];
            shift_rest <= shift_amt[`FXP_SHIFT_WID-1:`FXP_STEP1_WID];
            sign       <= float_val[`FLT_WID-1];

            zero   <= exp_zero & mant_zero;
            denorm <= exp_zero & ~mant_zero;
            nan    <= exp_ones & ~mant_zero;
            inf    <= exp_ones & mant_zero;

            overflow  <= (exp_f > EXP_HI) && (float_val != MIN_WORD);
            min_exact <= (float_val == MIN_WORD);
            underflow <= (exp_f < EXP_LO);
        end
    end

endmodule

// File: source/fxp_pkg.sv
`include "fxp_macros.svh"

package fxp_pkg;

    typedef logic [`FLT_WID-1:0]      float_word_t;
    typedef logic [`FLT_EXP_WID-1:0]  exp_t;
    typedef logic [`FLT_MANT_WID-1:0] mant_t;

    typedef logic [`FXP_SHIFT_WID-1:0]                  shift_t;
    typedef logic [`FXP_SHIFT_WID-`FXP_STEP1_WID-1:0]   shift_rest_t;  // steps 2 and 3

    // hidden one + mantissa, widened for the step-1 shift
    typedef logic [`FLT_MANT_WID+(1<<`FXP_STEP1_WID)-1:0] mant1_t;

    // shifted magnitude, guard bit at [0]
    typedef logic [`FXP_INT_WID+`FXP_FRA_WID:0] aligned_t;

    typedef logic signed [`FXP_INT_WID-1:0] fix_int_t;
    typedef logic        [`FXP_FRA_WID-1:0] fix_fra_t;

endpackage

// File: source/fxp_macros.svh
`ifndef FXP_MACROS_SVH
`define FXP_MACROS_SVH

// float32 layout
`define FLT_WID       32
`define FLT_EXP_WID   8
`define FLT_MANT_WID  23
`define FLT_EXP_BIAS  127

`define FXP_INT_WID   16  // incl sign bit
`define FXP_FRA_WID   16

// shift amount covers unbiased exponents -(FRA+1) .. INT-2, which is INT+FRA values
`define FXP_SHIFT_WID $clog2(`FXP_INT_WID + `FXP_FRA_WID)

`define FXP_STEP1_WID (`FXP_SHIFT_WID / 3)
`define FXP_STEP2_WID ((`FXP_SHIFT_WID - `FXP_STEP1_WID) / 2)
`define FXP_STEP3_WID (`FXP_SHIFT_WID - `FXP_STEP1_WID - `FXP_STEP2_WID)

`endif
